/* build.f */
hdl/ila_pkg.sv
hdl/line_buffer.sv
hdl/capture_ctrl.sv
hdl/sample_readout.sv
hdl/ila_top.sv
tb/ila_tb.sv

/* hdl/capture_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module capture_ctrl #(
  parameter  int LINE_WIDTH = 64,
  parameter  int MAX_LINES  = 16,
  localparam int ADDR_W     = (MAX_LINES > 1) ? $clog2(MAX_LINES) : 1
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [LINE_WIDTH-1:0]       probe_line,
  input  logic                        set_trigger,
  input  logic                        trigger_event,
  input  logic                        qualify,
  input  ila_pkg::capture_cfg_t       cfg,
  input  logic                        readout_busy,
  output logic                        wr_en,
  output logic [ADDR_W-1:0]           wr_addr,
  output logic [LINE_WIDTH-1:0]       wr_line,
  output logic                        capture_done,
  output logic [ila_pkg::BURST_W-1:0] lines_stored,
  output logic                        armed,
  output logic                        storing
);

  localparam logic [ila_pkg::BURST_W-1:0] MAX_LEN = ila_pkg::BURST_W'(MAX_LINES);

  ila_pkg::capture_state_e     state_q;
  ila_pkg::save_mode_e         mode_q;
  logic [ila_pkg::BURST_W-1:0] len_q;
  logic [ila_pkg::BURST_W-1:0] cnt_q;
  logic [ila_pkg::BURST_W-1:0] eff_len;
  logic                        store_hit;
  logic                        last_line;

  // zero means one line, anything past the buffer is cut to its depth
  always_comb begin
    if (cfg.burst_len == '0) begin
      eff_len = ila_pkg::BURST_W'(1);
    end else if (cfg.burst_len > MAX_LEN) begin
      eff_len = MAX_LEN;
    end else begin
      eff_len = cfg.burst_len;
    end
  end

  // trigger line always lands, later lines follow the save mode
  always_comb begin
    case (state_q)
      ila_pkg::CAP_ARMED: store_hit = trigger_event;
      ila_pkg::CAP_STORE: store_hit = (mode_q == ila_pkg::SAVE_ALL) || qualify;
      default:            store_hit = 1'b0;
    endcase
  end

  assign last_line    = store_hit && ((cnt_q + 1'b1) == len_q);
  assign wr_en        = store_hit;
  assign wr_addr      = cnt_q[ADDR_W-1:0];
  assign wr_line      = probe_line;
  assign capture_done = last_line;
  assign lines_stored = len_q;
  assign armed        = (state_q == ila_pkg::CAP_ARMED);
  assign storing      = (state_q == ila_pkg::CAP_STORE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ila_pkg::CAP_IDLE;
      mode_q  <= ila_pkg::SAVE_ALL;
      len_q   <= ila_pkg::BURST_W'(1);
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ila_pkg::CAP_IDLE: begin
          // no new arm until the previous burst has been read out
          if (set_trigger && !readout_busy) begin
            state_q <= ila_pkg::CAP_ARMED;
            mode_q  <= cfg.save_mode;
            len_q   <= eff_len;
            cnt_q   <= '0;
          end
        end
        ila_pkg::CAP_ARMED,
        ila_pkg::CAP_STORE: begin
          if (store_hit) begin
            if (last_line) begin
              state_q <= ila_pkg::CAP_IDLE;
            end else begin
              state_q <= ila_pkg::CAP_STORE;
              cnt_q   <= cnt_q + 1'b1;
            end
          end
        end
        default: state_q <= ila_pkg::CAP_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/ila_pkg.sv */
`default_nettype none

package ila_pkg;

  // burst length field width, so at most 255 lines per burst
  localparam int BURST_W = 8;

  typedef enum logic {
    SAVE_ALL,
    SAVE_QUALIFIED
  } save_mode_e;

  // sampled once, when an arm request is accepted
  typedef struct packed {
    save_mode_e             save_mode;
    logic [BURST_W-1:0]     burst_len;
  } capture_cfg_t;

  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_ARMED,
    CAP_STORE
  } capture_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_FETCH,
    RD_LOAD,
    RD_SEND
  } readout_state_e;

  typedef struct packed {
    logic armed;
    logic storing;
    logic reading;
  } ila_status_t;

endpackage

`default_nettype wire

/* hdl/ila_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ila_top #(
  parameter int LINE_WIDTH   = 64,
  parameter int SAMPLE_WIDTH = 16,
  parameter int MAX_LINES    = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [LINE_WIDTH-1:0] probe_line,
  input  logic                  set_trigger,
  input  logic                  trigger_event,
  input  logic                  qualify,
  input  ila_pkg::capture_cfg_t cfg,
  input  logic                  sample_pulled,
  output logic [SAMPLE_WIDTH-1:0] sample,
  output logic                  sample_valid,
  output ila_pkg::ila_status_t  status
);

  localparam int ADDR_W = (MAX_LINES > 1) ? $clog2(MAX_LINES) : 1;

  logic                        wr_en;
  logic [ADDR_W-1:0]           wr_addr;
  logic [LINE_WIDTH-1:0]       wr_line;
  logic                        rd_en;
  logic [ADDR_W-1:0]           rd_addr;
  logic [LINE_WIDTH-1:0]       rd_line;
  logic                        capture_done;
  logic [ila_pkg::BURST_W-1:0] lines_stored;
  logic                        armed;
  logic                        storing;
  logic                        busy;

  capture_ctrl #(.LINE_WIDTH(LINE_WIDTH), .MAX_LINES(MAX_LINES)) capture_i (
    .clk(clk), .rst(rst), .probe_line(probe_line), .set_trigger(set_trigger),
    .trigger_event(trigger_event), .qualify(qualify), .cfg(cfg),
    .readout_busy(busy), .wr_en(wr_en), .wr_addr(wr_addr), .wr_line(wr_line),
    .capture_done(capture_done), .lines_stored(lines_stored),
    .armed(armed), .storing(storing)
  );

  line_buffer #(.LINE_WIDTH(LINE_WIDTH), .MAX_LINES(MAX_LINES)) buffer_i (
    .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_line(wr_line),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_line(rd_line)
  );

  sample_readout #(
    .LINE_WIDTH(LINE_WIDTH), .SAMPLE_WIDTH(SAMPLE_WIDTH), .MAX_LINES(MAX_LINES)
  ) readout_i (
    .clk(clk), .rst(rst), .capture_done(capture_done), .lines_stored(lines_stored),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_line(rd_line),
    .sample_pulled(sample_pulled), .sample(sample), .sample_valid(sample_valid),
    .busy(busy)
  );

  // readout busy is reported as reading
  assign status = '{armed: armed, storing: storing, reading: busy};

endmodule

`default_nettype wire

/* hdl/line_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

// simple dual-port line store, inferred
module line_buffer #(
  parameter  int LINE_WIDTH = 64,
  parameter  int MAX_LINES  = 16,
  localparam int ADDR_W     = (MAX_LINES > 1) ? $clog2(MAX_LINES) : 1
) (
  input  logic                  clk,
  input  logic                  wr_en,
  input  logic [ADDR_W-1:0]     wr_addr,
  input  logic [LINE_WIDTH-1:0] wr_line,
  input  logic                  rd_en,
  input  logic [ADDR_W-1:0]     rd_addr,
  output logic [LINE_WIDTH-1:0] rd_line
);

  logic [LINE_WIDTH-1:0] mem [MAX_LINES];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_line;
    end
  end

  // one cycle read latency, output holds between reads
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_line <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* hdl/sample_readout.sv */
`timescale 1ns/100ps
`default_nettype none

module sample_readout #(
  parameter  int LINE_WIDTH   = 64,
  parameter  int SAMPLE_WIDTH = 16,
  parameter  int MAX_LINES    = 16,
  localparam int ADDR_W       = (MAX_LINES > 1) ? $clog2(MAX_LINES) : 1
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        capture_done,
  input  logic [ila_pkg::BURST_W-1:0] lines_stored,
  output logic                        rd_en,
  output logic [ADDR_W-1:0]           rd_addr,
  input  logic [LINE_WIDTH-1:0]       rd_line,
  input  logic                        sample_pulled,
  output logic [SAMPLE_WIDTH-1:0]     sample,
  output logic                        sample_valid,
  output logic                        busy
);

  localparam int               SLICES   = LINE_WIDTH / SAMPLE_WIDTH;
  localparam int               IDX_W    = (SLICES > 1) ? $clog2(SLICES) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(SLICES - 1);

  ila_pkg::readout_state_e            state_q;
  logic [ila_pkg::BURST_W-1:0]        lines_left_q;
  logic [ADDR_W-1:0]                  addr_q;
  logic [IDX_W-1:0]                   idx_q;
  logic [SLICES-1:0][SAMPLE_WIDTH-1:0] line_q;
  logic                               pull;
  logic                               last_slice;
  logic                               last_line;

  assign rd_en        = (state_q == ila_pkg::RD_FETCH);
  assign rd_addr      = addr_q;
  assign sample_valid = (state_q == ila_pkg::RD_SEND);
  assign busy         = (state_q != ila_pkg::RD_IDLE);

  // lowest slice of the line goes out first
  assign sample = line_q[idx_q];

  // pulls outside SEND are dropped
  assign pull       = sample_pulled && sample_valid;
  assign last_slice = (idx_q == LAST_IDX);
  assign last_line  = (lines_left_q == ila_pkg::BURST_W'(1));

  // held line, loaded one cycle after the read is issued
  always_ff @(posedge clk) begin
    if (state_q == ila_pkg::RD_LOAD) begin
      line_q <= rd_line;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= ila_pkg::RD_IDLE;
      lines_left_q <= '0;
      addr_q       <= '0;
      idx_q        <= '0;
    end else begin
      case (state_q)
        ila_pkg::RD_IDLE: begin
          if (capture_done) begin
            state_q      <= ila_pkg::RD_FETCH;
            lines_left_q <= lines_stored;
            addr_q       <= '0;
          end
        end
        ila_pkg::RD_FETCH: begin
          state_q <= ila_pkg::RD_LOAD;
        end
        ila_pkg::RD_LOAD: begin
          state_q <= ila_pkg::RD_SEND;
          idx_q   <= '0;
        end
        ila_pkg::RD_SEND: begin
          if (pull) begin
            if (!last_slice) begin
              idx_q <= idx_q + 1'b1;
            end else if (last_line) begin
              state_q <= ila_pkg::RD_IDLE;
            end else begin
              // next line, valid drops for fetch and load
              state_q      <= ila_pkg::RD_FETCH;
              addr_q       <= addr_q + 1'b1;
              lines_left_q <= lines_left_q - 1'b1;
            end
          end
        end
        default: state_q <= ila_pkg::RD_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile the testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module ila_tb -o ila_tb_sim

./obj_dir/ila_tb_sim

/* tb/ila_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ila_tb;

  localparam int LINE_WIDTH   = 48;
  localparam int SAMPLE_WIDTH = 16;
  localparam int MAX_LINES    = 8;
  localparam int SLICES       = LINE_WIDTH / SAMPLE_WIDTH;
  localparam int MAX_GAP      = 3;
  localparam int NUM_RUNS     = 4;
  localparam int CLK_NS       = 8;
  localparam int RESET_CYCLES = 8;
  localparam int LIMIT_CYCLES =
    NUM_RUNS * (MAX_LINES * (3 + 3 * MAX_GAP) + 50) + RESET_CYCLES;

  logic                    clk;
  logic                    rst;
  logic [LINE_WIDTH-1:0]   probe_line;
  logic                    set_trigger;
  logic                    trigger_event;
  logic                    qualify;
  ila_pkg::capture_cfg_t   cfg;
  logic                    sample_pulled;
  logic [SAMPLE_WIDTH-1:0] sample;
  logic                    sample_valid;
  ila_pkg::ila_status_t    status;

  // lines the buffer should hold, oldest first
  logic [LINE_WIDTH-1:0] model_q [$];
  logic [LINE_WIDTH-1:0] cur_line;
  int                    slice_idx;
  int                    lines_read;
  int                    lines_expected;
  logic [31:0]           stim_seed;
  logic [31:0]           pull_seed;

  ila_top #(
    .LINE_WIDTH(LINE_WIDTH), .SAMPLE_WIDTH(SAMPLE_WIDTH), .MAX_LINES(MAX_LINES)
  ) dut_i (
    .clk(clk), .rst(rst), .probe_line(probe_line), .set_trigger(set_trigger),
    .trigger_event(trigger_event), .qualify(qualify), .cfg(cfg),
    .sample_pulled(sample_pulled), .sample(sample), .sample_valid(sample_valid),
    .status(status)
  );

  initial clk = 1'b0;
  always #(CLK_NS / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // zero means one line, the buffer depth caps the rest
  function automatic int expected_lines(input int burst_len);
    if (burst_len == 0) return 1;
    if (burst_len > MAX_LINES) return MAX_LINES;
    return burst_len;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic next_line(output logic [LINE_WIDTH-1:0] line);
    logic [31:0] hi;
    stim_seed = lcg_next(stim_seed);
    hi = stim_seed;
    stim_seed = lcg_next(stim_seed);
    line = {hi[31:16], stim_seed};
  endtask

  // arm, wait a few cycles, trigger, then store until the burst is full
  task automatic capture_run(input ila_pkg::save_mode_e mode, input int burst_len);
    int                    want;
    int                    stored;
    int                    idle;
    logic                  q;
    logic [LINE_WIDTH-1:0] line;
    want = expected_lines(burst_len);
    lines_expected = lines_expected + want;
    @(posedge clk);
    cfg.save_mode <= mode;
    cfg.burst_len <= ila_pkg::BURST_W'(burst_len);
    set_trigger   <= 1'b1;
    @(posedge clk);
    set_trigger <= 1'b0;
    stim_seed = lcg_next(stim_seed);
    idle = int'(stim_seed[17:16]);
    repeat (idle) @(posedge clk);
    // trigger line is kept in either mode
    next_line(line);
    probe_line    <= line;
    trigger_event <= 1'b1;
    model_q.push_back(line);
    stored = 1;
    @(negedge clk);
    assert (status.armed && !status.storing)
      else stop_with_error($sformatf("arm not reported, status %b", status));
    while (stored < want) begin
      @(posedge clk);
      trigger_event <= 1'b0;
      next_line(line);
      probe_line <= line;
      stim_seed = lcg_next(stim_seed);
      q = stim_seed[20];
      qualify <= q;
      if (mode == ila_pkg::SAVE_ALL || q) begin
        model_q.push_back(line);
        stored = stored + 1;
      end
      @(negedge clk);
      assert (status.storing && !status.armed)
        else stop_with_error($sformatf("store not reported, status %b", status));
    end
    @(posedge clk);
    trigger_event <= 1'b0;
    qualify       <= 1'b0;
  endtask

  // readout is running once the burst is in, wait until it drains
  task automatic wait_readout_done();
    while (!status.reading) @(negedge clk);
    while (status.reading) @(negedge clk);
    assert (status == '0 && !sample_valid)
      else stop_with_error($sformatf("status %b not idle after readout", status));
    assert (lines_read == lines_expected)
      else stop_with_error($sformatf("reader saw %0d lines, expected %0d",
                                     lines_read, lines_expected));
  endtask

  initial begin
    rst            = 1'b1;
    probe_line     = '0;
    set_trigger    = 1'b0;
    trigger_event  = 1'b0;
    qualify        = 1'b0;
    cfg            = '0;
    stim_seed      = 32'hbada;
    lines_expected = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!sample_valid && status == '0)
      else stop_with_error($sformatf("after reset valid %b status %b", sample_valid, status));

    // trigger with nothing armed
    @(posedge clk);
    trigger_event <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      assert (status == '0)
        else stop_with_error($sformatf("unarmed trigger gave status %b", status));
    end
    @(posedge clk);
    trigger_event <= 1'b0;

    capture_run(ila_pkg::SAVE_ALL, 5);
    // arm request during readout has to be dropped
    while (!status.reading) @(negedge clk);
    @(posedge clk);
    cfg.burst_len <= ila_pkg::BURST_W'(2);
    set_trigger   <= 1'b1;
    @(posedge clk);
    set_trigger   <= 1'b0;
    trigger_event <= 1'b1;
    repeat (3) begin
      @(negedge clk);
      assert (!status.armed && !status.storing)
        else stop_with_error($sformatf("arm accepted while reading, status %b", status));
    end
    @(posedge clk);
    trigger_event <= 1'b0;
    wait_readout_done();

    capture_run(ila_pkg::SAVE_QUALIFIED, 6);
    wait_readout_done();
    capture_run(ila_pkg::SAVE_ALL, 0);
    wait_readout_done();
    capture_run(ila_pkg::SAVE_ALL, 20);
    wait_readout_done();

    $display("All checks passed");
    $finish;
  end

  // slow reader with random gaps between pulls
  initial begin : reader
    int                      gap_left;
    logic                    held;
    logic [SAMPLE_WIDTH-1:0] held_sample;
    logic [SAMPLE_WIDTH-1:0] want_sample;
    sample_pulled = 1'b0;
    slice_idx     = 0;
    lines_read    = 0;
    cur_line      = '0;
    pull_seed     = 32'hbada;
    gap_left      = 0;
    held          = 1'b0;
    held_sample   = '0;
    wait (rst === 1'b0);
    forever begin
      @(posedge clk);
      if (gap_left == 0) begin
        sample_pulled <= 1'b1;
      end else begin
        sample_pulled <= 1'b0;
        gap_left = gap_left - 1;
      end
      @(negedge clk);
      if (held) begin
        assert (sample_valid && sample == held_sample)
          else stop_with_error($sformatf("held sample %h changed to %h, valid %b",
                                         held_sample, sample, sample_valid));
      end
      held = sample_valid && !sample_pulled;
      held_sample = sample;
      if (sample_valid && sample_pulled) begin
        if (slice_idx == 0) begin
          assert (model_q.size() != 0)
            else stop_with_error($sformatf("unexpected sample %h, no line stored", sample));
          cur_line = model_q.pop_front();
        end
        want_sample = cur_line[slice_idx * SAMPLE_WIDTH +: SAMPLE_WIDTH];
        assert (sample == want_sample)
          else stop_with_error($sformatf("slice %0d got %h, expected %h",
                                         slice_idx, sample, want_sample));
        if (slice_idx == SLICES - 1) begin
          slice_idx  = 0;
          lines_read = lines_read + 1;
        end else begin
          slice_idx = slice_idx + 1;
        end
        pull_seed = lcg_next(pull_seed);
        gap_left = int'(pull_seed[17:16]) % (MAX_GAP + 1);
      end
    end
  end

  initial begin
    #(LIMIT_CYCLES * CLK_NS);
    $display("timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
